/* all.f */
hdl/icache_cfg_pkg.sv
hdl/icache_bus_pkg.sv
hdl/icache_tlb.sv
hdl/icache_array.sv
hdl/icache_ctrl.sv
hdl/icache_fill.sv
hdl/icache_top.sv
verification/icache_props.sv
verification/icache_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := icache_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verification/icache_tb.sv */
`default_nettype none

module icache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period  = 4;
  localparam int num_requests = 400;
  localparam int max_cycles   = num_requests * 50;  // Slow grant, gapped burst and stalls.

  logic        clk;
  logic        reset;
  logic        read_valid;
  logic [15:0] read_addr;
  logic        read_ready;
  logic        dp_valid;
  logic [31:0] dp_data;
  logic        dp_fault;
  logic        dp_ready;
  logic        tlb_we;
  logic [1:0]  tlb_slot;
  logic [7:0]  tlb_vpn;
  logic [7:0]  tlb_ppn_in;
  logic        bus_req;
  logic        bus_grant;
  logic        bus_busy;
  logic [15:0] bus_addr;
  logic        bus_rvalid;
  logic [31:0] bus_rdata;

  logic [31:0] lcg_state = 32'h18ebfef5;
  int unsigned cycles = 0;
  logic        exp_fault;
  logic        exp_hit;
  logic [31:0] exp_data;
  logic [15:0] exp_line;
  logic [9:0]  line_tag [16];  // Shadow of the direct-mapped tags.
  logic [15:0] line_valid;
  logic        accept;
  logic        resp_xfer;

  assign accept    = read_valid && read_ready;
  assign resp_xfer = dp_valid && dp_ready;

  icache_top dut0 (.*);

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Bus memory contents: address in the upper half, its complement below.
  function automatic logic [31:0] mem_word(input logic [15:0] pa);
    return {pa, ~pa};
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped on a failed check.");
  endtask

  assert property (@(posedge clk) disable iff (reset) resp_xfer |-> dp_fault == exp_fault)
    else stop_run($sformatf("Fail at time %0t: fault flag %b, expected %b",
                            $time, $sampled(dp_fault), exp_fault));
  assert property (@(posedge clk) disable iff (reset)
    resp_xfer && !exp_fault |-> dp_data == exp_data)
    else stop_run($sformatf("Fail at time %0t: data %h, expected %h",
                            $time, $sampled(dp_data), exp_data));
  assert property (@(posedge clk) disable iff (reset)
    accept && (exp_hit || exp_fault) |=> !dp_valid ##1 dp_valid)
    else stop_run($sformatf("Fail at time %0t: hit or fault response not 2 cycles after accept",
                            $time));
  assert property (@(posedge clk) disable iff (reset)
    !read_ready && (exp_hit || exp_fault) |-> !bus_req)
    else stop_run($sformatf("Fail at time %0t: bus request on a hit or fault", $time));
  assert property (@(posedge clk) disable iff (reset)
    bus_req && bus_grant && !bus_busy |-> bus_addr == exp_line)
    else stop_run($sformatf("Fail at time %0t: bus address %h, expected %h",
                            $time, $sampled(bus_addr), exp_line));

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      stop_run($sformatf("Timeout after %0d cycles, a request never completed.", max_cycles));
    end
  end

  // Grant, busy and beat gaps are random every cycle.
  initial begin : bus_model
    logic [31:0] r;
    logic [15:0] base;
    int          beat;
    bus_grant  = 1'b0;
    bus_busy   = 1'b0;
    bus_rvalid = 1'b0;
    bus_rdata  = '0;
    base       = '0;
    beat       = icache_bus_pkg::beats;  // No burst pending.
    forever begin
      @(negedge clk);
      r = next_random();
      bus_grant  = (r[31:30] != 2'b00);
      bus_busy   = (r[29:28] == 2'b00);
      bus_rvalid = 1'b0;
      if (beat < icache_bus_pkg::beats && r[27:26] != 2'b00) begin
        bus_rvalid = 1'b1;
        bus_rdata  = mem_word(base + 16'(beat));
        beat       = beat + 1;
      end
      if (bus_req && bus_grant && !bus_busy) begin
        #1;
        base = bus_addr;  // Settled address of the grant cycle.
        beat = 0;
      end
    end
  end

  task automatic issue(input logic [15:0] addr);
    logic [7:0]  vpn;
    logic [15:0] pa;
    logic [31:0] r;
    vpn = addr[15:8];
    pa  = {vpn ^ 8'h5A, addr[7:0]};
    @(negedge clk);
    exp_fault  = (vpn > 8'd3);
    exp_data   = mem_word(pa);
    exp_line   = {pa[15:2], 2'b00};
    exp_hit    = !exp_fault && line_valid[pa[5:2]] && (line_tag[pa[5:2]] == pa[15:6]);
    read_valid = 1'b1;
    read_addr  = addr;
    while (!read_ready) @(negedge clk);
    @(negedge clk);
    read_valid = 1'b0;
    r          = next_random();
    dp_ready   = (r[31:30] != 2'b00);
    while (!(dp_valid && dp_ready)) begin
      @(negedge clk);
      r        = next_random();
      dp_ready = (r[31:30] != 2'b00);
    end
    if (!exp_fault) begin
      line_valid[pa[5:2]] = 1'b1;
      line_tag[pa[5:2]]   = pa[15:6];
    end
  endtask

  initial begin : stimulus
    logic [31:0] r;
    logic [15:0] addr;
    logic [15:0] prev;
    reset      = 1'b1;
    read_valid = 1'b0;
    read_addr  = '0;
    dp_ready   = 1'b0;
    tlb_we     = 1'b0;
    tlb_slot   = '0;
    tlb_vpn    = '0;
    tlb_ppn_in = '0;
    exp_fault  = 1'b0;
    exp_hit    = 1'b0;
    exp_data   = '0;
    exp_line   = '0;
    line_valid = '0;
    prev       = 16'h000c;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < 4; i++) begin
      tlb_we     = 1'b1;
      tlb_slot   = i[1:0];
      tlb_vpn    = {6'd0, i[1:0]};
      tlb_ppn_in = {6'd0, i[1:0]} ^ 8'h5A;
      @(negedge clk);
    end
    tlb_we = 1'b0;
    // Two lines on index 3 evict each other.
    issue(16'h000c);
    issue(16'h010c);
    issue(16'h000d);
    issue(16'h010e);
    for (int n = 0; n < num_requests; n++) begin
      r = next_random();
      if (r[31]) begin
        addr = {prev[15:2], r[25:24]};  // Another word of the last line.
      end else if (r[30:28] == 3'd0) begin
        addr = {2'b01, r[27:22], r[21:14]};
      end else begin
        addr = {6'd0, r[23:22], r[21:14]};
      end
      issue(addr);
      prev = addr;
    end
    @(negedge clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/icache_props.sv */
`default_nettype none

module icache_props (
  input wire                                  clk,
  input wire                                  reset,
  input wire                                  read_valid,
  input wire                                  read_ready,
  input wire                                  dp_valid,
  input wire                                  dp_ready,
  input wire [icache_cfg_pkg::data_w-1:0]     dp_data,
  input wire                                  dp_fault,
  input wire                                  bus_req,
  input wire                                  bus_grant,
  input wire                                  bus_busy,
  input wire [icache_bus_pkg::bus_addr_w-1:0] bus_addr
);
  timeunit 1ns;
  timeprecision 100ps;

  logic granted;

  assign granted = bus_req && bus_grant && !bus_busy;  // Address phase of a fill.

  assert property (@(posedge clk) disable iff (reset)
    dp_valid && !dp_ready |=> dp_valid && $stable(dp_data) && $stable(dp_fault))
    else $error("Response changed while the datapath stalled.");

  // Fetch side stays closed from acceptance until the response handshake.
  assert property (@(posedge clk) disable iff (reset) read_valid && read_ready |=> !read_ready)
    else $error("Fetch port still ready after acceptance.");
  assert property (@(posedge clk) disable iff (reset)
    !read_ready && !(dp_valid && dp_ready) |=> !read_ready)
    else $error("Fetch port reopened before the response handshake.");
  assert property (@(posedge clk) disable iff (reset) dp_valid && dp_ready |=> read_ready)
    else $error("Controller did not return to idle after the handshake.");

  assert property (@(posedge clk) disable iff (reset) bus_req && !granted |=> bus_req)
    else $error("Bus request dropped before the grant.");
  assert property (@(posedge clk) disable iff (reset) granted |=> !bus_req)
    else $error("Bus request still high after the grant cycle.");
  assert property (@(posedge clk) disable iff (reset)
    granted |-> bus_addr[icache_cfg_pkg::offset_w-1:0] == '0)
    else $error("Bus address in the grant cycle is not a line address.");

endmodule

bind icache_ctrl icache_props ctrl_props0 (
  .clk(clk), .reset(reset), .read_valid(read_valid), .read_ready(read_ready),
  .dp_valid(dp_valid), .dp_ready(dp_ready), .dp_data(dp_data), .dp_fault(dp_fault),
  .bus_req(1'b0), .bus_grant(1'b0), .bus_busy(1'b0), .bus_addr('0)
);

bind icache_fill icache_props fill_props0 (
  .clk(clk), .reset(reset), .read_valid(1'b0), .read_ready(1'b0),
  .dp_valid(1'b0), .dp_ready(1'b0), .dp_data('0), .dp_fault(1'b0),
  .bus_req(bus_req), .bus_grant(bus_grant), .bus_busy(bus_busy), .bus_addr(bus_addr)
);

`default_nettype wire

/* hdl/icache_top.sv */
`default_nettype none

module icache_top (
  input  wire                                  clk,
  input  wire                                  reset,
  input  wire                                  read_valid,
  input  wire [icache_cfg_pkg::addr_w-1:0]     read_addr,
  output wire                                  read_ready,
  output wire                                  dp_valid,
  output wire [icache_cfg_pkg::data_w-1:0]     dp_data,
  output wire                                  dp_fault,
  input  wire                                  dp_ready,
  input  wire                                  tlb_we,
  input  wire [icache_cfg_pkg::slot_w-1:0]     tlb_slot,
  input  wire [icache_cfg_pkg::vpn_w-1:0]      tlb_vpn,
  input  wire [icache_cfg_pkg::ppn_w-1:0]      tlb_ppn_in,
  output wire                                  bus_req,
  input  wire                                  bus_grant,
  input  wire                                  bus_busy,
  output wire [icache_bus_pkg::bus_addr_w-1:0] bus_addr,
  input  wire                                  bus_rvalid,
  input  wire [icache_bus_pkg::bus_data_w-1:0] bus_rdata
);

  wire [icache_cfg_pkg::vpn_w-1:0]    lookup_vpn;
  wire                                tlb_hit;
  wire [icache_cfg_pkg::ppn_w-1:0]    tlb_ppn;
  wire                                rd_en;
  wire [icache_cfg_pkg::index_w-1:0]  rd_index;
  wire [icache_cfg_pkg::offset_w-1:0] rd_offset;
  wire [icache_cfg_pkg::tag_w-1:0]    rd_tag;
  wire                                rd_valid;
  wire [icache_cfg_pkg::data_w-1:0]   rd_word;
  wire                                fill_start;
  wire [icache_cfg_pkg::addr_w-1:0]   fill_addr;  // Physical line address.
  wire                                fill_done;
  wire                                wr_en;
  wire [icache_cfg_pkg::index_w-1:0]  wr_index;
  wire [icache_cfg_pkg::offset_w-1:0] wr_offset;
  wire [icache_cfg_pkg::data_w-1:0]   wr_word;
  wire [icache_cfg_pkg::tag_w-1:0]    wr_tag;
  wire                                set_valid;

  icache_ctrl ctrl0 (
    .clk(clk), .reset(reset),
    .read_valid(read_valid), .read_addr(read_addr), .read_ready(read_ready),
    .dp_ready(dp_ready), .dp_valid(dp_valid), .dp_data(dp_data), .dp_fault(dp_fault),
    .lookup_vpn(lookup_vpn), .tlb_hit(tlb_hit), .tlb_ppn(tlb_ppn),
    .rd_en(rd_en), .rd_index(rd_index), .rd_offset(rd_offset),
    .rd_tag(rd_tag), .rd_valid(rd_valid), .rd_word(rd_word),
    .fill_start(fill_start), .fill_addr(fill_addr), .fill_done(fill_done)
  );

  icache_tlb tlb0 (
    .clk(clk), .reset(reset),
    .tlb_we(tlb_we), .tlb_slot(tlb_slot), .tlb_vpn(tlb_vpn), .tlb_ppn_in(tlb_ppn_in),
    .lookup_vpn(lookup_vpn), .tlb_hit(tlb_hit), .tlb_ppn(tlb_ppn)
  );

  icache_array array0 (
    .clk(clk), .reset(reset),
    .rd_en(rd_en), .rd_index(rd_index), .rd_offset(rd_offset),
    .rd_tag(rd_tag), .rd_valid(rd_valid), .rd_word(rd_word),
    .wr_en(wr_en), .wr_index(wr_index), .wr_offset(wr_offset),
    .wr_word(wr_word), .wr_tag(wr_tag), .set_valid(set_valid)
  );

  icache_fill fill0 (
    .clk(clk), .reset(reset),
    .fill_start(fill_start), .fill_addr(fill_addr), .fill_done(fill_done),
    .bus_req(bus_req), .bus_addr(bus_addr), .bus_grant(bus_grant), .bus_busy(bus_busy),
    .bus_rvalid(bus_rvalid), .bus_rdata(bus_rdata),
    .wr_en(wr_en), .wr_index(wr_index), .wr_offset(wr_offset),
    .wr_word(wr_word), .wr_tag(wr_tag), .set_valid(set_valid)
  );

endmodule

`default_nettype wire

/* hdl/icache_fill.sv */
`default_nettype none

module icache_fill (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire                                   fill_start,
  input  wire icache_cfg_pkg::addr_u            fill_addr,
  output logic                                  fill_done,
  output logic                                  bus_req,
  output logic [icache_bus_pkg::bus_addr_w-1:0] bus_addr,
  input  wire                                   bus_grant,
  input  wire                                   bus_busy,
  input  wire                                   bus_rvalid,
  input  wire [icache_bus_pkg::bus_data_w-1:0]  bus_rdata,
  output logic                                  wr_en,
  output logic [icache_cfg_pkg::index_w-1:0]    wr_index,
  output logic [icache_cfg_pkg::offset_w-1:0]   wr_offset,
  output logic [icache_cfg_pkg::data_w-1:0]     wr_word,
  output logic [icache_cfg_pkg::tag_w-1:0]      wr_tag,
  output logic                                  set_valid
);

  logic [icache_bus_pkg::fill_state_w-1:0] state;
  logic [icache_bus_pkg::beat_w-1:0]       beat_cnt;
  icache_cfg_pkg::addr_u                   line_addr;
  logic                                    granted;
  logic                                    last_beat;

  assign bus_req  = (state == icache_bus_pkg::fs_req);
  assign granted  = bus_req && bus_grant && !bus_busy;
  assign bus_addr = granted ? line_addr : '0;  // Address phase is the grant cycle.

  // Each beat becomes one array write, in offset order.
  assign wr_en     = (state == icache_bus_pkg::fs_burst) && bus_rvalid;
  assign last_beat = wr_en && (beat_cnt == icache_bus_pkg::beat_w'(icache_bus_pkg::beats - 1));
  assign wr_index  = line_addr.cache_view.index;
  assign wr_offset = beat_cnt;
  assign wr_word   = bus_rdata;
  assign wr_tag    = line_addr.cache_view.tag;
  assign set_valid = last_beat;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= icache_bus_pkg::fs_idle;
      beat_cnt  <= '0;
      fill_done <= 1'b0;
    end else begin
      fill_done <= last_beat;  // Line is written by now.
      case (state)
        icache_bus_pkg::fs_idle: begin
          if (fill_start) state <= icache_bus_pkg::fs_req;
        end
        icache_bus_pkg::fs_req: begin
          if (granted) begin
            state    <= icache_bus_pkg::fs_burst;
            beat_cnt <= '0;
          end
        end
        icache_bus_pkg::fs_burst: begin
          if (wr_en) beat_cnt <= beat_cnt + 1'b1;
          if (last_beat) state <= icache_bus_pkg::fs_idle;
        end
        default: state <= icache_bus_pkg::fs_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fill_start) line_addr <= fill_addr;
  end

endmodule

`default_nettype wire

/* hdl/icache_ctrl.sv */
`default_nettype none

module icache_ctrl (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 read_valid,
  input  wire icache_cfg_pkg::addr_u          read_addr,
  output logic                                read_ready,
  input  wire                                 dp_ready,
  output logic                                dp_valid,
  output logic [icache_cfg_pkg::data_w-1:0]   dp_data,
  output logic                                dp_fault,
  output logic [icache_cfg_pkg::vpn_w-1:0]    lookup_vpn,
  input  wire                                 tlb_hit,
  input  wire [icache_cfg_pkg::ppn_w-1:0]     tlb_ppn,
  output logic                                rd_en,
  output logic [icache_cfg_pkg::index_w-1:0]  rd_index,
  output logic [icache_cfg_pkg::offset_w-1:0] rd_offset,
  input  wire [icache_cfg_pkg::tag_w-1:0]     rd_tag,
  input  wire                                 rd_valid,
  input  wire [icache_cfg_pkg::data_w-1:0]    rd_word,
  output logic                                fill_start,
  output icache_cfg_pkg::addr_u               fill_addr,
  input  wire                                 fill_done
);

  logic [icache_cfg_pkg::state_w-1:0] state;
  logic [icache_cfg_pkg::state_w-1:0] next_state;
  icache_cfg_pkg::addr_u              req_addr;
  icache_cfg_pkg::addr_u              phys_addr;
  logic                               req_addr_en;
  logic                               line_hit;

  assign read_ready  = (state == icache_cfg_pkg::st_idle);
  assign req_addr_en = read_valid && read_ready;
  assign dp_valid    = (state == icache_cfg_pkg::st_respond);

  // Translate the latched request; page offset passes through.
  assign lookup_vpn = req_addr.page_view.vpn;
  assign phys_addr  = {tlb_ppn, req_addr.page_view.page_off};
  assign line_hit   = rd_valid && (rd_tag == phys_addr.cache_view.tag);

  // Read starts at acceptance, or again once the fill has landed.
  assign rd_en     = req_addr_en || (state == icache_cfg_pkg::st_reread);
  assign rd_index  = read_ready ? read_addr.cache_view.index : req_addr.cache_view.index;
  assign rd_offset = read_ready ? read_addr.cache_view.offset : req_addr.cache_view.offset;

  always_comb begin
    next_state = state;
    case (state)
      icache_cfg_pkg::st_idle: begin
        if (req_addr_en) next_state = icache_cfg_pkg::st_lookup;
      end
      icache_cfg_pkg::st_lookup: begin
        if (!tlb_hit || line_hit) begin
          next_state = icache_cfg_pkg::st_respond;  // Fault or hit.
        end else begin
          next_state = icache_cfg_pkg::st_fill_wait;
        end
      end
      icache_cfg_pkg::st_respond: begin
        if (dp_ready) next_state = icache_cfg_pkg::st_idle;
      end
      icache_cfg_pkg::st_fill_wait: begin
        if (fill_done) next_state = icache_cfg_pkg::st_reread;
      end
      icache_cfg_pkg::st_reread: next_state = icache_cfg_pkg::st_lookup;
      default: next_state = icache_cfg_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= icache_cfg_pkg::st_idle;
      fill_start <= 1'b0;
    end else begin
      state      <= next_state;
      fill_start <= (state == icache_cfg_pkg::st_lookup) && tlb_hit && !line_hit;
    end
  end

  // Response only loads in lookup, so it holds through back-pressure.
  always_ff @(posedge clk) begin
    if (req_addr_en) begin
      req_addr <= read_addr;
    end
    if (state == icache_cfg_pkg::st_lookup) begin
      dp_data                   <= tlb_hit ? rd_word : '0;
      dp_fault                  <= !tlb_hit;
      fill_addr.cache_view.tag    <= phys_addr.cache_view.tag;
      fill_addr.cache_view.index  <= phys_addr.cache_view.index;
      fill_addr.cache_view.offset <= '0;  // Line address.
    end
  end

endmodule

`default_nettype wire

/* hdl/icache_array.sv */
`default_nettype none

module icache_array (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 rd_en,
  input  wire [icache_cfg_pkg::index_w-1:0]   rd_index,
  input  wire [icache_cfg_pkg::offset_w-1:0]  rd_offset,
  output logic [icache_cfg_pkg::tag_w-1:0]    rd_tag,
  output logic                                rd_valid,
  output logic [icache_cfg_pkg::data_w-1:0]   rd_word,
  input  wire                                 wr_en,
  input  wire [icache_cfg_pkg::index_w-1:0]   wr_index,
  input  wire [icache_cfg_pkg::offset_w-1:0]  wr_offset,
  input  wire [icache_cfg_pkg::data_w-1:0]    wr_word,
  input  wire [icache_cfg_pkg::tag_w-1:0]     wr_tag,
  input  wire                                 set_valid
);

  logic [icache_cfg_pkg::tag_w-1:0]  tag_mem [icache_cfg_pkg::lines];
  logic [icache_cfg_pkg::lines-1:0]  valid;
  logic [icache_cfg_pkg::data_w-1:0] data_mem [icache_cfg_pkg::lines * icache_cfg_pkg::line_words];

  // A line is invalid from its first fill beat until the last one lands.
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (wr_en) begin
      if (set_valid) begin
        valid[wr_index] <= 1'b1;
      end else if (wr_offset == '0) begin
        valid[wr_index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[{wr_index, wr_offset}] <= wr_word;
    end
    if (wr_en && set_valid) begin
      tag_mem[wr_index] <= wr_tag;  // Tag only changes with the last beat.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else if (rd_en) begin
      rd_valid <= valid[rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_tag  <= tag_mem[rd_index];
      rd_word <= data_mem[{rd_index, rd_offset}];
    end
  end

endmodule

`default_nettype wire

/* hdl/icache_tlb.sv */
`default_nettype none

module icache_tlb (
  input  wire                               clk,
  input  wire                               reset,
  input  wire                               tlb_we,
  input  wire [icache_cfg_pkg::slot_w-1:0]  tlb_slot,
  input  wire [icache_cfg_pkg::vpn_w-1:0]   tlb_vpn,
  input  wire [icache_cfg_pkg::ppn_w-1:0]   tlb_ppn_in,
  input  wire [icache_cfg_pkg::vpn_w-1:0]   lookup_vpn,
  output logic                              tlb_hit,
  output logic [icache_cfg_pkg::ppn_w-1:0]  tlb_ppn
);

  logic [icache_cfg_pkg::tlb_entries-1:0] valid;
  logic [icache_cfg_pkg::vpn_w-1:0]       vpn_tab [icache_cfg_pkg::tlb_entries];
  logic [icache_cfg_pkg::ppn_w-1:0]       ppn_tab [icache_cfg_pkg::tlb_entries];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (tlb_we) begin
      valid[tlb_slot] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tlb_we) begin
      vpn_tab[tlb_slot] <= tlb_vpn;
      ppn_tab[tlb_slot] <= tlb_ppn_in;
    end
  end

  // Software keeps vpns unique, so at most one entry matches.
  always_comb begin
    tlb_hit = 1'b0;
    tlb_ppn = '0;
    for (int i = 0; i < icache_cfg_pkg::tlb_entries; i++) begin
      if (valid[i] && (vpn_tab[i] == lookup_vpn)) begin
        tlb_hit = 1'b1;
        tlb_ppn = tlb_ppn | ppn_tab[i];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/icache_bus_pkg.sv */
`default_nettype none

package icache_bus_pkg;

  localparam int bus_addr_w = 16;  // Word address of the first word of a line.
  localparam int bus_data_w = 32;

  // One refill is a burst of a whole line.
  localparam int beats  = 4;
  localparam int beat_w = 2;

  // Fill unit states.
  localparam int fill_state_w = 2;
  localparam logic [fill_state_w-1:0] fs_idle  = 2'd0;
  localparam logic [fill_state_w-1:0] fs_req   = 2'd1;  // Waiting for grant.
  localparam logic [fill_state_w-1:0] fs_burst = 2'd2;

endpackage

`default_nettype wire

/* hdl/icache_cfg_pkg.sv */
`default_nettype none

package icache_cfg_pkg;

  localparam int addr_w     = 16;  // Word address, virtual and physical.
  localparam int data_w     = 32;  // One instruction word.
  localparam int offset_w   = 2;
  localparam int index_w    = 4;
  localparam int tag_w      = 10;
  localparam int lines      = 16;
  localparam int line_words = 4;

  // Index and offset sit inside the page offset, so the array is indexed virtually.
  localparam int page_off_w  = 8;
  localparam int vpn_w       = 8;
  localparam int ppn_w       = 8;
  localparam int tlb_entries = 4;
  localparam int slot_w      = $clog2(tlb_entries);

  // Controller states.
  localparam int state_w = 3;
  localparam logic [state_w-1:0] st_idle      = 3'd0;
  localparam logic [state_w-1:0] st_lookup    = 3'd1;
  localparam logic [state_w-1:0] st_respond   = 3'd2;
  localparam logic [state_w-1:0] st_fill_wait = 3'd3;
  localparam logic [state_w-1:0] st_reread    = 3'd4;

  typedef union packed {
    struct packed {
      logic [tag_w-1:0]    tag;
      logic [index_w-1:0]  index;
      logic [offset_w-1:0] offset;
    } cache_view;  // Used by the array and the fill unit.
    struct packed {
      logic [vpn_w-1:0]      vpn;
      logic [page_off_w-1:0] page_off;
    } page_view;  // Used by the TLB and the controller.
  } addr_u;

endpackage

`default_nettype wire
